// File: source/mp_mem_pkg.sv
`default_nettype none

package mp_mem_pkg;

  // memory geometry
  localparam int WIDTH   = 32;
  localparam int NUMVBNK = 4;
  localparam int NUMPBNK = NUMVBNK + 1;
  localparam int BITVBNK = 2;
  localparam int BITPBNK = 3;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;
  // low address bits pick the virtual bank, high bits pick the row
  localparam int BITADDR = BITVBNK + BITVROW;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] vbnk_t;
  typedef logic [BITPBNK-1:0] pbnk_t;
  typedef logic [BITVROW-1:0] row_t;

  typedef struct packed {
    logic  write;
    addr_t adr;
    data_t din;
  } wr_cmd_t;

  typedef struct packed {
    logic  read;
    addr_t adr;
  } rd_cmd_t;

  typedef struct packed {
    logic  write;
    row_t  row;
    data_t din;
  } bank_wr_t;

  // moves one virtual bank of a row to a new physical bank
  typedef struct packed {
    logic  en;
    row_t  row;
    vbnk_t vbnk;
    pbnk_t new_pbnk;
    pbnk_t new_free;
  } map_upd_t;

  typedef enum logic {
    INIT_CLEAR,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

// File: source/mp_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_bank (
  input  wire                        clk,
  input  wire  [1:0]                 rd_en,
  input  wire  mp_mem_pkg::row_t [1:0] rd_row,
  output mp_mem_pkg::data_t [1:0]    rd_data,
  input  wire  mp_mem_pkg::bank_wr_t wr
);

  mp_mem_pkg::data_t mem [mp_mem_pkg::NUMVROW];

  // single write port
  always_ff @(posedge clk) begin
    if (wr.write) begin
      mem[wr.row] <= wr.din;
    end
  end

  // two registered read ports that miss a same-cycle write
  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (rd_en[k]) begin
        rd_data[k] <= mem[rd_row[k]];
      end
    end
  end

  for (genvar k = 0; k < 2; k++) begin : g_row_chk
    a_rd_row_known: assert property (
      @(posedge clk) rd_en[k] |-> !$isunknown(rd_row[k])
    ) else $error("bank read port %0d row is unknown", k);
  end

endmodule

`default_nettype wire

// File: source/mp_mem_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_map_table (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  mp_mem_pkg::row_t [1:0] wr_row,
  input  wire  mp_mem_pkg::row_t [1:0] rd_row,
  output mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] wr_map,
  output mp_mem_pkg::pbnk_t [1:0] wr_free,
  output mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] rd_map,
  input  wire  mp_mem_pkg::map_upd_t [1:0] upd,
  output logic                         ready
);

  mp_mem_pkg::pbnk_t [mp_mem_pkg::NUMVBNK-1:0] map_q [mp_mem_pkg::NUMVROW];
  mp_mem_pkg::pbnk_t                           free_q [mp_mem_pkg::NUMVROW];

  mp_mem_pkg::init_state_t state_q;
  mp_mem_pkg::row_t        init_row_q;
  logic                    map_ok;

  // init sequencer, one row per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= mp_mem_pkg::INIT_CLEAR;
      init_row_q <= '0;
    end else if (state_q == mp_mem_pkg::INIT_CLEAR) begin
      init_row_q <= init_row_q + 1'b1;
      if (init_row_q == mp_mem_pkg::row_t'(mp_mem_pkg::NUMVROW - 1)) begin
        state_q <= mp_mem_pkg::INIT_DONE;
      end
    end
  end

  assign ready = (state_q == mp_mem_pkg::INIT_DONE);

  // map storage, filled by the sequencer and then by steering updates
  always_ff @(posedge clk) begin
    if (state_q == mp_mem_pkg::INIT_CLEAR) begin
      for (int v = 0; v < mp_mem_pkg::NUMVBNK; v++) begin
        map_q[init_row_q][v] <= mp_mem_pkg::pbnk_t'(v);
      end
      // spare slot sits past the last virtual bank
      free_q[init_row_q] <= mp_mem_pkg::pbnk_t'(mp_mem_pkg::NUMVBNK);
    end else begin
      // update 1 is applied last so it wins on overlap
      for (int i = 0; i < 2; i++) begin
        if (upd[i].en) begin
          map_q[upd[i].row][upd[i].vbnk] <= upd[i].new_pbnk;
          free_q[upd[i].row]             <= upd[i].new_free;
        end
      end
    end
  end

  // combinational lookups for each port
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      wr_map[k]  = map_q[wr_row[k]];
      wr_free[k] = free_q[wr_row[k]];
      rd_map[k]  = map_q[rd_row[k]];
    end
  end

  // free slot of every row must stay apart from its mapped banks
  always_comb begin
    map_ok = 1'b1;
    for (int r = 0; r < mp_mem_pkg::NUMVROW; r++) begin
      for (int v = 0; v < mp_mem_pkg::NUMVBNK; v++) begin
        if (free_q[r] == map_q[r][v]) begin
          map_ok = 1'b0;
        end
      end
    end
  end

  a_upd_after_ready: assert property (
    @(posedge clk) disable iff (!rst_n) (upd[0].en || upd[1].en) |-> ready
  ) else $error("map update before init done");

  a_free_unique: assert property (
    @(posedge clk) disable iff (!rst_n) ready |-> map_ok
  ) else $error("free bank collides with a mapped bank");

endmodule

`default_nettype wire

// File: source/mp_mem_write_steer.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_write_steer (
  input  wire                              ready,
  input  wire  mp_mem_pkg::wr_cmd_t [1:0]  wr,
  input  wire  mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] wr_map,
  input  wire  mp_mem_pkg::pbnk_t [1:0]    wr_free,
  output mp_mem_pkg::row_t [1:0]           wr_row,
  output mp_mem_pkg::bank_wr_t [mp_mem_pkg::NUMPBNK-1:0] bank_wr,
  output mp_mem_pkg::map_upd_t [1:0]       upd
);

  logic [1:0]               vld;
  logic [1:0]               move;
  logic                     conflict;
  mp_mem_pkg::vbnk_t [1:0]  wr_vbnk;
  mp_mem_pkg::pbnk_t [1:0]  cur_pbnk;
  mp_mem_pkg::pbnk_t [1:0]  dst_pbnk;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      wr_row[k]   = wr[k].adr[mp_mem_pkg::BITADDR-1:mp_mem_pkg::BITVBNK];
      wr_vbnk[k]  = wr[k].adr[mp_mem_pkg::BITVBNK-1:0];
      cur_pbnk[k] = wr_map[k][wr_vbnk[k]];
    end
  end

  // wr1 overrides wr0 on the same address
  assign vld[1] = ready & wr[1].write;
  assign vld[0] = ready & wr[0].write & ~(wr[1].write && (wr[0].adr == wr[1].adr));

  // same physical bank means different rows, so wr1 can take its row's spare
  assign conflict = vld[0] & vld[1] & (cur_pbnk[0] == cur_pbnk[1]);

  // wr0 keeps its bank, only wr1 ever relocates
  assign move = {conflict, 1'b0};

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      dst_pbnk[k] = move[k] ? wr_free[k] : cur_pbnk[k];
    end
  end

  always_comb begin
    for (int p = 0; p < mp_mem_pkg::NUMPBNK; p++) begin
      bank_wr[p] = '0;
      for (int k = 0; k < 2; k++) begin
        if (vld[k] && (dst_pbnk[k] == mp_mem_pkg::pbnk_t'(p))) begin
          bank_wr[p].write = 1'b1;
          bank_wr[p].row   = wr_row[k];
          bank_wr[p].din   = wr[k].din;
        end
      end
    end
  end

  // relocated bank becomes the row's new spare
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      upd[k].en       = move[k];
      upd[k].row      = wr_row[k];
      upd[k].vbnk     = wr_vbnk[k];
      upd[k].new_pbnk = wr_free[k];
      upd[k].new_free = cur_pbnk[k];
    end
  end

  // relies on the map keeping each row's spare apart from its used banks
  always_comb begin
    a_one_wr_per_bank: assert final (!(vld[0] && vld[1]) || (dst_pbnk[0] != dst_pbnk[1]))
      else $error("two writes steered to bank %0d", dst_pbnk[0]);
  end

endmodule

`default_nettype wire

// File: source/mp_mem_read_path.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_read_path (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             ready,
  input  wire  mp_mem_pkg::rd_cmd_t [1:0] rd,
  input  wire  mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] rd_map,
  output mp_mem_pkg::row_t [1:0]          rd_row,
  output logic [mp_mem_pkg::NUMPBNK-1:0][1:0] bank_rd_en,
  output mp_mem_pkg::row_t [1:0]          bank_rd_row,
  input  wire  mp_mem_pkg::data_t [mp_mem_pkg::NUMPBNK-1:0][1:0] bank_rd_data,
  output logic [1:0]                      rd_vld,
  output mp_mem_pkg::data_t [1:0]         rd_dout
);

  logic [1:0]               vld;
  logic [1:0]               vld_q;
  mp_mem_pkg::vbnk_t [1:0]  rd_vbnk;
  mp_mem_pkg::pbnk_t [1:0]  rd_pbnk;
  mp_mem_pkg::pbnk_t [1:0]  pbnk_q;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      vld[k]     = ready & rd[k].read;
      rd_row[k]  = rd[k].adr[mp_mem_pkg::BITADDR-1:mp_mem_pkg::BITVBNK];
      rd_vbnk[k] = rd[k].adr[mp_mem_pkg::BITVBNK-1:0];
      rd_pbnk[k] = rd_map[k][rd_vbnk[k]];
    end
  end

  // every bank sees both rows, only the mapped one is enabled
  assign bank_rd_row = rd_row;

  always_comb begin
    for (int p = 0; p < mp_mem_pkg::NUMPBNK; p++) begin
      for (int k = 0; k < 2; k++) begin
        bank_rd_en[p][k] = vld[k] && (rd_pbnk[k] == mp_mem_pkg::pbnk_t'(p));
      end
    end
  end

  // remember which bank answers port k next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= '0;
      pbnk_q <= '0;
    end else begin
      vld_q  <= vld;
      pbnk_q <= rd_pbnk;
    end
  end

  assign rd_vld = vld_q;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      rd_dout[k] = bank_rd_data[pbnk_q[k]][k];
    end
  end

endmodule

`default_nettype wire

// File: source/mp_mem_2r2w_top.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_2r2w_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire  mp_mem_pkg::wr_cmd_t  wr0,
  input  wire  mp_mem_pkg::wr_cmd_t  wr1,
  input  wire  mp_mem_pkg::rd_cmd_t  rd0,
  input  wire  mp_mem_pkg::rd_cmd_t  rd1,
  output logic [1:0]                 rd_vld,
  output mp_mem_pkg::data_t [1:0]    rd_dout,
  output logic                       ready
);

  mp_mem_pkg::wr_cmd_t [1:0]  wr;
  mp_mem_pkg::rd_cmd_t [1:0]  rd;
  mp_mem_pkg::row_t [1:0]     wr_row;
  mp_mem_pkg::row_t [1:0]     rd_row;
  mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] wr_map;
  mp_mem_pkg::pbnk_t [1:0][mp_mem_pkg::NUMVBNK-1:0] rd_map;
  mp_mem_pkg::pbnk_t [1:0]    wr_free;
  mp_mem_pkg::map_upd_t [1:0] upd;
  mp_mem_pkg::bank_wr_t [mp_mem_pkg::NUMPBNK-1:0] bank_wr;
  logic [mp_mem_pkg::NUMPBNK-1:0][1:0]            bank_rd_en;
  mp_mem_pkg::row_t [1:0]                         bank_rd_row;
  mp_mem_pkg::data_t [mp_mem_pkg::NUMPBNK-1:0][1:0] bank_rd_data;

  assign wr = {wr1, wr0};
  assign rd = {rd1, rd0};

  mp_mem_map_table mp_mem_map_table_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_row  (wr_row),
    .rd_row  (rd_row),
    .wr_map  (wr_map),
    .wr_free (wr_free),
    .rd_map  (rd_map),
    .upd     (upd),
    .ready   (ready)
  );

  mp_mem_write_steer mp_mem_write_steer_i (
    .ready   (ready),
    .wr      (wr),
    .wr_map  (wr_map),
    .wr_free (wr_free),
    .wr_row  (wr_row),
    .bank_wr (bank_wr),
    .upd     (upd)
  );

  mp_mem_read_path mp_mem_read_path_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ready        (ready),
    .rd           (rd),
    .rd_map       (rd_map),
    .rd_row       (rd_row),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_row  (bank_rd_row),
    .bank_rd_data (bank_rd_data),
    .rd_vld       (rd_vld),
    .rd_dout      (rd_dout)
  );

  // NUMVBNK data banks plus one spare
  for (genvar p = 0; p < mp_mem_pkg::NUMPBNK; p++) begin : g_bank
    mp_mem_bank mp_mem_bank_i (
      .clk     (clk),
      .rd_en   (bank_rd_en[p]),
      .rd_row  (bank_rd_row),
      .rd_data (bank_rd_data[p]),
      .wr      (bank_wr[p])
    );
  end

endmodule

`default_nettype wire

// File: verif/mp_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mp_mem_tb;

  localparam int RESET_CYCLES = 8;
  localparam int INIT_CYCLES  = 16;
  localparam int RANDOM_ROWS  = 200;
  localparam int NUMADDR      = 2 ** mp_mem_pkg::BITADDR;

  logic                    clk;
  logic                    rst_n;
  mp_mem_pkg::wr_cmd_t     wr0;
  mp_mem_pkg::wr_cmd_t     wr1;
  mp_mem_pkg::rd_cmd_t     rd0;
  mp_mem_pkg::rd_cmd_t     rd1;
  logic [1:0]              rd_vld;
  mp_mem_pkg::data_t [1:0] rd_dout;
  logic                    ready;

  // stimulus table with one entry per clock cycle
  mp_mem_pkg::wr_cmd_t tbl_wr0 [$];
  mp_mem_pkg::wr_cmd_t tbl_wr1 [$];
  mp_mem_pkg::rd_cmd_t tbl_rd0 [$];
  mp_mem_pkg::rd_cmd_t tbl_rd1 [$];

  // reference memory
  mp_mem_pkg::data_t ref_mem [NUMADDR];

  int err_cnt;
  int seed;
  bit table_built;

  mp_mem_2r2w_top mp_mem_2r2w_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr0     (wr0),
    .wr1     (wr1),
    .rd0     (rd0),
    .rd1     (rd1),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .ready   (ready)
  );

  always #5 clk = ~clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic mp_mem_pkg::wr_cmd_t make_wr(input int adr, input mp_mem_pkg::data_t din);
    mp_mem_pkg::wr_cmd_t c;
    c.write = 1'b1;
    c.adr   = mp_mem_pkg::addr_t'(adr);
    c.din   = din;
    return c;
  endfunction

  function automatic mp_mem_pkg::rd_cmd_t make_rd(input int adr);
    mp_mem_pkg::rd_cmd_t c;
    c.read = 1'b1;
    c.adr  = mp_mem_pkg::addr_t'(adr);
    return c;
  endfunction

  // every address bit shows up in the word
  function automatic mp_mem_pkg::data_t fill_word(input int a);
    return 32'h5A00_0000 | (a * 32'h0001_0101);
  endfunction

  task automatic add_row(input mp_mem_pkg::wr_cmd_t w0, input mp_mem_pkg::wr_cmd_t w1,
                         input mp_mem_pkg::rd_cmd_t r0, input mp_mem_pkg::rd_cmd_t r1);
    tbl_wr0.push_back(w0);
    tbl_wr1.push_back(w1);
    tbl_rd0.push_back(r0);
    tbl_rd1.push_back(r1);
  endtask

  task automatic build_table();
    mp_mem_pkg::wr_cmd_t w0;
    mp_mem_pkg::wr_cmd_t w1;
    mp_mem_pkg::rd_cmd_t r0;
    mp_mem_pkg::rd_cmd_t r1;
    // a and a+32 share a virtual bank in different rows and so every fill row conflicts
    for (int a = 0; a < NUMADDR / 2; a++) begin
      add_row(make_wr(a, fill_word(a)), make_wr(a + 32, fill_word(a + 32)), '0, '0);
    end
    // single write followed by a read on either port
    add_row(make_wr(5, 32'h1111_0005), '0, '0, '0);
    add_row('0, '0, make_rd(5), '0);
    add_row('0, '0, '0, make_rd(5));
    // chained conflicts on rows 2 and 7 where each wr1 moves into the spare the previous one freed
    for (int j = 0; j < mp_mem_pkg::NUMVBNK; j++) begin
      add_row(make_wr(8 + j, 32'hC0F0_0800 + j), make_wr(28 + j, 32'hC0F0_2800 + j), '0, '0);
      add_row('0, '0, make_rd(8 + j), make_rd(28 + j));
    end
    // address 29 now shares bank 0 with address 8 and row 2 takes its spare this time
    add_row(make_wr(29, 32'hC0F1_2900), make_wr(8, 32'hC0F1_0800), '0, '0);
    add_row('0, '0, make_rd(29), make_rd(8));
    // same address on both write ports
    add_row(make_wr(12, 32'hAAAA_0012), make_wr(12, 32'hBBBB_0012), '0, '0);
    add_row('0, '0, make_rd(12), make_rd(12));
    // read alongside a write to the same address and again one cycle later
    add_row(make_wr(20, 32'hDDDD_0020), '0, make_rd(20), '0);
    add_row('0, '0, '0, make_rd(20));
    seed = 45176;
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      w0.write = 1'($random(seed));
      w0.adr   = mp_mem_pkg::addr_t'($random(seed));
      w0.din   = $random(seed);
      w1.write = 1'($random(seed));
      w1.adr   = mp_mem_pkg::addr_t'($random(seed));
      w1.din   = $random(seed);
      // push some rows onto a shared address
      if ($random(seed) % 8 == 0) begin
        w1.adr = w0.adr;
      end
      r0.read = 1'($random(seed));
      r0.adr  = mp_mem_pkg::addr_t'($random(seed));
      r1.read = 1'($random(seed));
      r1.adr  = 1'($random(seed)) ? w1.adr : w0.adr;
      add_row(w0, w1, r0, r1);
    end
  endtask

  initial begin
    int                cycles;
    logic [1:0]        exp_vld;
    mp_mem_pkg::data_t exp_dout [2];
    clk     = 1'b0;
    rst_n   = 1'b0;
    wr0     = '0;
    wr1     = '0;
    rd0     = '0;
    rd1     = '0;
    err_cnt = 0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_value(32'(ready), 32'd0, "ready during reset");
    end
    rst_n = 1'b1;
    // reads during map init must be dropped
    rd0    = make_rd(0);
    rd1    = make_rd(1);
    cycles = 0;
    while (ready !== 1'b1) begin
      @(posedge clk);
      #1;
      cycles++;
      check_value(32'(rd_vld), 32'd0, "rd_vld before ready");
    end
    check_value(cycles, INIT_CYCLES, "cycles from reset release to ready");
    for (int i = 0; i < tbl_wr0.size(); i++) begin
      wr0 = tbl_wr0[i];
      wr1 = tbl_wr1[i];
      rd0 = tbl_rd0[i];
      rd1 = tbl_rd1[i];
      // reads see the memory from before this cycle's writes
      exp_vld     = {rd1.read, rd0.read};
      exp_dout[0] = ref_mem[rd0.adr];
      exp_dout[1] = ref_mem[rd1.adr];
      // wr1 lands last and so wins on a shared address
      if (wr0.write) begin
        ref_mem[wr0.adr] = wr0.din;
      end
      if (wr1.write) begin
        ref_mem[wr1.adr] = wr1.din;
      end
      @(posedge clk);
      #1;
      check_value(32'(ready), 32'd1, "ready after init");
      check_value(32'(rd_vld), 32'(exp_vld), $sformatf("row %0d rd_vld", i));
      for (int k = 0; k < 2; k++) begin
        if (exp_vld[k]) begin
          check_value(rd_dout[k], exp_dout[k], $sformatf("row %0d rd%0d data", i, k));
        end
      end
    end
    wr0 = '0;
    wr1 = '0;
    rd0 = '0;
    rd1 = '0;
    $display("mp_mem_tb done, %0d rows, %0d errors", tbl_wr0.size(), err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from reset, init and table length plus margin
  initial begin
    int limit_ns;
    wait (table_built);
    limit_ns = (RESET_CYCLES + INIT_CYCLES + tbl_wr0.size() + 20) * 10;
    #(limit_ns);
    $display("timeout: the run did not complete within %0d ns", limit_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: mp_mem.f
source/mp_mem_pkg.sv
source/mp_mem_bank.sv
source/mp_mem_map_table.sv
source/mp_mem_write_steer.sv
source/mp_mem_read_path.sv
source/mp_mem_2r2w_top.sv
verif/mp_mem_tb.sv

// File: Makefile
TOP := mp_mem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mp_mem.f source/*.sv verif/*.sv
	verilator --binary --timing -j 0 -f mp_mem.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only --timing -f mp_mem.f --top-module $(TOP)
	verilator --lint-only \
	  source/mp_mem_pkg.sv source/mp_mem_bank.sv source/mp_mem_map_table.sv \
	  source/mp_mem_write_steer.sv source/mp_mem_read_path.sv \
	  source/mp_mem_2r2w_top.sv --top-module mp_mem_2r2w_top

clean:
	rm -rf obj_dir
